// ==== rtl/commutation_cfg.svh ====
`ifndef COMMUTATION_CFG_SVH
`define COMMUTATION_CFG_SVH

// Encoder steps in one electrical cycle.
`define CYCLE_STEPS 1170

// A third of the electrical cycle, 120 degrees.
`define PHASE_STEPS 390

// Peak value stored in the signed sine table.
`define SINE_AMPL 511

// PWM counter width, which also sets the duty width.
// The period is 2**PWM_BITS clocks.
`define PWM_BITS 10

`endif

// ==== rtl/wb_pkg.sv ====
package wb_pkg;

    // Master to slave, held steady until ack.
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    // Slave to master.
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // Byte addresses of the register map.
    typedef enum logic [3:0] {
        REG_CTRL     = 4'h0,
        REG_GAIN     = 4'h4,
        REG_STATUS   = 4'h8,
        REG_POSITION = 4'hC
    } reg_addr_e;

endpackage

// ==== rtl/motor_pkg.sv ====
`include "commutation_cfg.svh"

package motor_pkg;

    // Electrical angle in encoder steps, 0 to CYCLE_STEPS-1.
    typedef logic [10:0] angle_t;

    // Raw encoder value before the range check.
    typedef logic [12:0] position_t;

    typedef logic signed [9:0] sine_t;

    typedef logic [`PWM_BITS-1:0] duty_t;

    typedef logic [9:0] gain_t;

    typedef struct packed {
        angle_t a;
        angle_t b;
        angle_t c;
    } phase_angles_t;

    typedef struct packed {
        duty_t a;
        duty_t b;
        duty_t c;
    } phase_duty_t;

endpackage

// ==== rtl/wb_ctrl_regs.sv ====
`timescale 1ns/1ps
`include "commutation_cfg.svh"

module wb_ctrl_regs (
    input  logic                 clk,
    input  logic                 reset,
    input  wb_pkg::wb_req_t      wb_req,
    input  motor_pkg::position_t cycle_position,
    output wb_pkg::wb_rsp_t      wb_rsp,
    output logic                 enable,
    output motor_pkg::gain_t     gain,
    output motor_pkg::angle_t    valid_position
);

    wb_pkg::reg_addr_e addr;
    logic              wb_access;
    logic              wb_write;
    logic              position_ok;
    logic              range_err;
    logic [31:0]       read_data;

    assign addr = wb_pkg::reg_addr_e'(wb_req.adr);

    // No new access while ack is high, so ack lasts one cycle.
    assign wb_access = wb_req.cyc && wb_req.stb && !wb_rsp.ack;
    assign wb_write  = wb_access && wb_req.we;

    assign position_ok = cycle_position < 13'(`CYCLE_STEPS);

    always_comb
    begin
        case (addr)
            wb_pkg::REG_CTRL:     read_data = 32'(enable);
            wb_pkg::REG_GAIN:     read_data = 32'(gain);
            wb_pkg::REG_STATUS:   read_data = 32'(range_err);
            wb_pkg::REG_POSITION: read_data = 32'(valid_position);
            default:              read_data = '0;
        endcase
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            wb_rsp <= '0;
        end
        else
        begin
            wb_rsp.ack <= wb_access;
            if (wb_access)
                wb_rsp.dat <= read_data;
        end
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            enable    <= 1'b0;
            gain      <= '0;
            range_err <= 1'b0;
        end
        else
        begin
            if (wb_write && addr == wb_pkg::REG_CTRL)
                enable <= wb_req.dat[0];
            if (wb_write && addr == wb_pkg::REG_GAIN)
                gain <= wb_req.dat[9:0];
            // A new range error wins over a clear in the same cycle.
            if (!position_ok)
                range_err <= 1'b1;
            else if (wb_write && addr == wb_pkg::REG_STATUS && wb_req.dat[0])
                range_err <= 1'b0;
        end
    end

    // Out of range values are dropped and the last good one is kept.
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            valid_position <= '0;
        else if (position_ok)
            valid_position <= motor_pkg::angle_t'(cycle_position);
    end

endmodule

// ==== rtl/phase_angle_offset.sv ====
`timescale 1ns/1ps
`include "commutation_cfg.svh"

module phase_angle_offset (
    input  logic                     clk,
    input  logic                     reset,
    input  motor_pkg::angle_t        valid_position,
    output motor_pkg::phase_angles_t angles
);

    logic [11:0]       plus_sum;
    logic [11:0]       minus_diff;
    logic              overflow;
    logic              underflow;
    motor_pkg::angle_t angle_lead;
    motor_pkg::angle_t angle_lag;

    // Phase a leads by 120 degrees.
    assign plus_sum = {1'b0, valid_position} + 12'(`PHASE_STEPS);
    assign overflow = plus_sum >= 12'(`CYCLE_STEPS);

    always_comb
    begin
        if (overflow)
            angle_lead = motor_pkg::angle_t'(plus_sum - 12'(`CYCLE_STEPS));
        else
            angle_lead = motor_pkg::angle_t'(plus_sum);
    end

    // Phase c lags by 120 degrees; the top bit is the borrow.
    assign minus_diff = {1'b0, valid_position} - 12'(`PHASE_STEPS);
    assign underflow  = minus_diff[11];

    always_comb
    begin
        if (underflow)
            angle_lag = motor_pkg::angle_t'(minus_diff + 12'(`CYCLE_STEPS));
        else
            angle_lag = motor_pkg::angle_t'(minus_diff);
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            angles <= '0;
        end
        else
        begin
            angles.a <= angle_lead;
            angles.b <= valid_position;
            angles.c <= angle_lag;
        end
    end

endmodule

// ==== rtl/sine_amplitude_table.sv ====
`timescale 1ns/1ps
`include "commutation_cfg.svh"

module sine_amplitude_table (
    input  logic                     clk,
    input  logic                     reset,
    input  motor_pkg::phase_angles_t angles,
    input  motor_pkg::gain_t         gain,
    input  logic                     enable,
    output motor_pkg::phase_duty_t   duty
);

    localparam real TWO_PI = 6.283185307179586;

    motor_pkg::sine_t sine_rom [`CYCLE_STEPS];
    motor_pkg::sine_t sine_a;
    motor_pkg::sine_t sine_b;
    motor_pkg::sine_t sine_c;

    // Table entry, rounded half away from zero.
    function automatic motor_pkg::sine_t sine_entry(input int idx);
        real value;
        int  rounded;
        value = real'(`SINE_AMPL) * $sin(TWO_PI * real'(idx) / real'(`CYCLE_STEPS));
        if (value >= 0.0)
            rounded = $rtoi(value + 0.5);
        else
            rounded = -$rtoi(0.5 - value);
        return motor_pkg::sine_t'(rounded);
    endfunction

    // Signed sine times gain over 1024, floored, then moved to mid-scale.
    function automatic motor_pkg::duty_t scale_bias(
        input motor_pkg::sine_t s,
        input motor_pkg::gain_t g
    );
        logic signed [20:0] product;
        logic signed [10:0] scaled;
        product = s * $signed({1'b0, g});
        scaled  = 11'(product >>> 10);
        return motor_pkg::duty_t'(scaled + 11'sd512);
    endfunction

    initial
    begin
        for (int i = 0; i < `CYCLE_STEPS; i++)
            sine_rom[i] = sine_entry(i);
    end

    assign sine_a = sine_rom[angles.a];
    assign sine_b = sine_rom[angles.b];
    assign sine_c = sine_rom[angles.c];

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            duty <= '0;
        end
        else if (!enable)
        begin
            duty <= '0;
        end
        else
        begin
            duty.a <= scale_bias(sine_a, gain);
            duty.b <= scale_bias(sine_b, gain);
            duty.c <= scale_bias(sine_c, gain);
        end
    end

endmodule

// ==== rtl/pwm_generator.sv ====
`timescale 1ns/1ps
`include "commutation_cfg.svh"

module pwm_generator (
    input  logic             clk,
    input  logic             reset,
    input  motor_pkg::duty_t duty,
    output logic             pwm
);

    logic [`PWM_BITS-1:0] count;
    motor_pkg::duty_t     duty_shadow;
    logic                 period_end;

    assign period_end = &count;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            count <= '0;
        else
            count <= count + 1'b1;
    end

    // Duty changes only at the wrap, so a period never gets cut short.
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            duty_shadow <= '0;
        else if (period_end)
            duty_shadow <= duty;
    end

    // Edge aligned: high from the period start until the duty count.
    assign pwm = count < duty_shadow;

endmodule

// ==== rtl/motor_commutation.sv ====
`timescale 1ns/1ps

module motor_commutation (
    input  logic                 clk,
    input  logic                 reset,
    input  wb_pkg::wb_req_t      wb_req,
    input  motor_pkg::position_t cycle_position,
    output wb_pkg::wb_rsp_t      wb_rsp,
    output logic                 pwm_a,
    output logic                 pwm_b,
    output logic                 pwm_c
);

    logic                     enable;
    motor_pkg::gain_t         gain;
    motor_pkg::angle_t        valid_position;
    motor_pkg::phase_angles_t angles;
    motor_pkg::phase_duty_t   duty;

    wb_ctrl_regs u_regs (
        .clk            (clk),
        .reset          (reset),
        .wb_req         (wb_req),
        .cycle_position (cycle_position),
        .wb_rsp         (wb_rsp),
        .enable         (enable),
        .gain           (gain),
        .valid_position (valid_position)
    );

    phase_angle_offset u_offset (
        .clk            (clk),
        .reset          (reset),
        .valid_position (valid_position),
        .angles         (angles)
    );

    sine_amplitude_table u_sine (
        .clk    (clk),
        .reset  (reset),
        .angles (angles),
        .gain   (gain),
        .enable (enable),
        .duty   (duty)
    );

    pwm_generator u_pwm_a (.clk(clk), .reset(reset), .duty(duty.a), .pwm(pwm_a));
    pwm_generator u_pwm_b (.clk(clk), .reset(reset), .duty(duty.b), .pwm(pwm_b));
    pwm_generator u_pwm_c (.clk(clk), .reset(reset), .duty(duty.c), .pwm(pwm_c));

endmodule

// ==== verification/motor_commutation_sva.sv ====
`timescale 1ns/1ps
`include "commutation_cfg.svh"

module motor_commutation_sva (
    input logic                     clk,
    input logic                     reset,
    input wb_pkg::wb_req_t          wb_req,
    input wb_pkg::wb_rsp_t          wb_rsp,
    input motor_pkg::phase_angles_t angles
);

    // An ack only answers a live request.
    ack_with_request: assert property (@(posedge clk) disable iff (reset)
        wb_rsp.ack |-> wb_req.cyc && wb_req.stb)
        else $error("Wishbone ack without cyc and stb");

    ack_single_cycle: assert property (@(posedge clk) disable iff (reset)
        wb_rsp.ack |=> !wb_rsp.ack)
        else $error("Wishbone ack high on two cycles in a row");

    // All three angles stay inside one electrical cycle.
    angle_a_range: assert property (@(posedge clk) disable iff (reset)
        angles.a < 11'(`CYCLE_STEPS))
        else $error("Phase a angle out of range");

    angle_b_range: assert property (@(posedge clk) disable iff (reset)
        angles.b < 11'(`CYCLE_STEPS))
        else $error("Phase b angle out of range");

    angle_c_range: assert property (@(posedge clk) disable iff (reset)
        angles.c < 11'(`CYCLE_STEPS))
        else $error("Phase c angle out of range");

endmodule

bind motor_commutation motor_commutation_sva u_sva (
    .clk    (clk),
    .reset  (reset),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .angles (angles)
);

// ==== verification/motor_commutation_tb.sv ====
`timescale 1ns/1ps
`include "commutation_cfg.svh"

module motor_commutation_tb;

    localparam real TWO_PI = 6.283185307179586;

    logic                 clk;
    logic                 reset;
    wb_pkg::wb_req_t      wb_req;
    wb_pkg::wb_rsp_t      wb_rsp;
    motor_pkg::position_t cycle_position;
    logic                 pwm_a;
    logic                 pwm_b;
    logic                 pwm_c;

    int seed;
    int test_errors;
    int error_count;
    int test_count;
    int failed_tests;
    int high_a;
    int high_b;
    int high_c;

    motor_commutation uut (
        .clk            (clk),
        .reset          (reset),
        .wb_req         (wb_req),
        .cycle_position (cycle_position),
        .wb_rsp         (wb_rsp),
        .pwm_a          (pwm_a),
        .pwm_b          (pwm_b),
        .pwm_c          (pwm_c)
    );

    always #10 clk = ~clk;

    function automatic int wrap_angle(input int angle);
        return (angle + `CYCLE_STEPS) % `CYCLE_STEPS;
    endfunction

    // Rounded sine times gain over 1024, floored, on top of mid-scale.
    function automatic int expected_duty(input int angle, input int gain_value, input bit enabled);
        real sine_value;
        int  sine_rounded;
        if (!enabled)
            return 0;
        sine_value   = real'(`SINE_AMPL) * $sin(TWO_PI * real'(angle) / real'(`CYCLE_STEPS));
        sine_rounded = $rtoi($floor(sine_value + 0.5));
        return 512 + $rtoi($floor(real'(sine_rounded * gain_value) / 1024.0));
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        assert (expected == actual)
        else
        begin
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic wb_cycle(input bit we, input logic [3:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
        wb_pkg::wb_req_t req;
        int              waited;
        req     = '0;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = we;
        req.adr = adr;
        req.dat = wdat;
        @(posedge clk);
        wb_req <= req;
        waited = 0;
        do
        begin
            @(negedge clk);
            waited++;
        end
        while (!wb_rsp.ack && waited < 20);
        assert (wb_rsp.ack)
        else
        begin
            $display("Wishbone access to address 0x%0h got no ack", adr);
            test_errors++;
        end
        rdat = wb_rsp.dat;
        @(posedge clk);
        wb_req <= '0;
    endtask

    task automatic wb_write(input logic [3:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        wb_cycle(1'b1, adr, wdat, unused);
    endtask

    task automatic wb_read(input logic [3:0] adr, output logic [31:0] rdat);
        wb_cycle(1'b0, adr, '0, rdat);
    endtask

    // Reads a register and compares it with the expected value.
    task automatic read_check(input string name, input logic [3:0] adr, input int expected);
        logic [31:0] rdat;
        wb_read(adr, rdat);
        check_value(name, expected, int'(rdat));
    endtask

    task automatic set_position(input int pos);
        @(posedge clk);
        cycle_position <= 13'(pos);
    endtask

    // Two full PWM periods give a high count of twice the duty.
    task automatic measure_duty();
        repeat (2100) @(posedge clk);
        high_a = 0;
        high_b = 0;
        high_c = 0;
        repeat (2048)
        begin
            @(negedge clk);
            high_a += int'(pwm_a);
            high_b += int'(pwm_b);
            high_c += int'(pwm_c);
        end
    endtask

    task automatic check_phase_duties(input string name, input int pos, input int gain_value,
                                      input bit enabled);
        measure_duty();
        check_value({name, " phase a"},
                    2 * expected_duty(wrap_angle(pos + `PHASE_STEPS), gain_value, enabled), high_a);
        check_value({name, " phase b"}, 2 * expected_duty(pos, gain_value, enabled), high_b);
        check_value({name, " phase c"},
                    2 * expected_duty(wrap_angle(pos - `PHASE_STEPS), gain_value, enabled), high_c);
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0)
            $display("%s: passed", name);
        else
            $display("%s: failed with %0d errors", name, test_errors);
        test_count++;
        if (test_errors != 0)
            failed_tests++;
        error_count += test_errors;
        test_errors = 0;
    endtask

    task automatic test_reset_defaults();
        read_check("reset CTRL", 4'h0, 0);
        read_check("reset GAIN", 4'h4, 0);
        read_check("reset STATUS", 4'h8, 0);
        read_check("reset POSITION", 4'hC, 0);
        check_phase_duties("reset outputs", 0, 0, 1'b0);
        finish_test("reset defaults");
    endtask

    task automatic test_register_access();
        wb_write(4'h0, 32'h1);
        read_check("CTRL readback", 4'h0, 1);
        wb_write(4'h4, 32'h2a5);
        read_check("GAIN readback", 4'h4, 'h2a5);
        // Bit 0 low and a gain field unlike 0x2a5, so a stray decode shows up.
        wb_write(4'h2, 32'hffff_fffe);
        read_check("unmapped read", 4'h2, 0);
        read_check("CTRL after unmapped write", 4'h0, 1);
        read_check("GAIN after unmapped write", 4'h4, 'h2a5);
        set_position(700);
        read_check("POSITION readback", 4'hC, 700);
        finish_test("register access");
    endtask

    task automatic test_duty_rule();
        int positions [4] = '{0, 292, 585, 877};
        wb_write(4'h0, 32'h1);
        wb_write(4'h4, 32'd1023);
        foreach (positions[i])
        begin
            set_position(positions[i]);
            check_phase_duties($sformatf("gain 1023 pos %0d", positions[i]), positions[i], 1023, 1);
        end
        wb_write(4'h4, 32'd300);
        foreach (positions[i])
        begin
            set_position(positions[i]);
            check_phase_duties($sformatf("gain 300 pos %0d", positions[i]), positions[i], 300, 1);
        end
        finish_test("duty by rule");
    endtask

    task automatic test_phase_relation();
        int unsigned rnd;
        int          pos;
        wb_write(4'h4, 32'd1023);
        for (int i = 0; i < 10; i++)
        begin
            rnd = $random(seed);
            // The first six sit next to the wrap point.
            if (i < 3)
                pos = int'(rnd % 20);
            else if (i < 6)
                pos = `CYCLE_STEPS - 1 - int'(rnd % 20);
            else
                pos = int'(rnd % `CYCLE_STEPS);
            set_position(pos);
            check_phase_duties($sformatf("random pos %0d", pos), pos, 1023, 1);
        end
        finish_test("120-degree relation");
    endtask

    task automatic test_range_check();
        set_position(200);
        read_check("STATUS before error", 4'h8, 0);
        set_position(`CYCLE_STEPS);
        read_check("POSITION held", 4'hC, 200);
        read_check("STATUS error set", 4'h8, 1);
        check_phase_duties("duty held", 200, 1023, 1);
        set_position(200);
        wb_write(4'h8, 32'h1);
        read_check("STATUS cleared", 4'h8, 0);
        finish_test("range check");
    endtask

    task automatic test_enable_gating();
        set_position(400);
        wb_write(4'h0, 32'h0);
        check_phase_duties("disabled", 400, 1023, 0);
        wb_write(4'h0, 32'h1);
        check_phase_duties("enabled again", 400, 1023, 1);
        finish_test("enable gating");
    endtask

    initial
    begin
        clk            = 1'b0;
        reset          = 1'b1;
        wb_req         = '0;
        cycle_position = '0;
        seed           = 32'hfee3;
        test_errors    = 0;
        error_count    = 0;
        test_count     = 0;
        failed_tests   = 0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        test_reset_defaults();
        test_register_access();
        test_duty_rule();
        test_phase_relation();
        test_range_check();
        test_enable_gating();
        $display("Tests run: %0d, failed: %0d, errors: %0d", test_count, failed_tests, error_count);
        if (error_count == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+rtl
rtl/wb_pkg.sv
rtl/motor_pkg.sv
rtl/wb_ctrl_regs.sv
rtl/phase_angle_offset.sv
rtl/sine_amplitude_table.sv
rtl/pwm_generator.sv
rtl/motor_commutation.sv
verification/motor_commutation_sva.sv
verification/motor_commutation_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build with Verilator and run the testbench from the project root.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module motor_commutation_tb \
    -f compile.f -o sim_motor_commutation \
    && ./obj_dir/sim_motor_commutation > sim.log 2>&1 \
    || echo "Simulation FAILED" >> sim.log
cat sim.log
# A build error, a crash or a failed check all leave the fail message in the log.
grep -q "Simulation FAILED" sim.log && exit 1 || exit 0
